// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_fp_noncomp_slice
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
PASS_MSG   := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F -q -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== common/fp_fmt_pkg.sv ====
// Floating-point format definitions for the multi-format slice
// Widths, field sizes, lane layout and canonical quiet NaNs

package fp_fmt_pkg;

  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned NUM_LANES   = 4;
  localparam int unsigned NUM_FMTS    = 3;

  typedef enum logic [1:0] {
    FP32 = 2'd0,
    FP16 = 2'd1,
    FP8  = 2'd2
  } fp_fmt_e;

  // Per-format tables, indexed by fp_fmt_e
  localparam int unsigned FP_WIDTH [NUM_FMTS] = '{32, 16, 8};
  localparam int unsigned EXP_BITS [NUM_FMTS] = '{8, 5, 5};
  localparam int unsigned MAN_BITS [NUM_FMTS] = '{23, 10, 2};

  localparam bit [SLICE_WIDTH-1:0] CANON_NAN [NUM_FMTS] = '{
    32'h7fc0_0000,
    32'h0000_7e00,
    32'h0000_007e
  };

  // ------------------------------
  // Lane layout
  // ------------------------------
  localparam int unsigned LANE_WIDTH [NUM_LANES] = '{32, 16, 8, 8};

  // Bit f set when the lane handles format f
  localparam bit [NUM_FMTS-1:0] lane_fmt_ok [NUM_LANES] = '{
    3'b111,
    3'b110,
    3'b100,
    3'b100
  };

  // Mask of lanes that carry a result for this format
  function automatic logic [NUM_LANES-1:0] lanes_used(fp_fmt_e fmt, logic vectorial);
    logic [NUM_LANES-1:0] mask;
    mask = NUM_LANES'(1);
    if (vectorial && (fmt <= FP8)) begin
      for (int unsigned l = 1; l < NUM_LANES; l++) begin
        if (l < SLICE_WIDTH / FP_WIDTH[fmt]) begin
          mask[l] = 1'b1;
        end
      end
    end
    return mask;
  endfunction

endpackage

// ==== common/fp_op_pkg.sv ====
// Operation, status and pipeline payload definitions
// for the non-computational slice

package fp_op_pkg;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4
  } fp_op_e;

  // IEEE 754 exception flags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_status_t;

  localparam int unsigned TAG_WIDTH = 8;

  // Sideband that travels with each item
  typedef struct packed {
    fp_fmt_pkg::fp_fmt_e  fmt;
    logic                 vectorial;
    logic [TAG_WIDTH-1:0] tag;
  } slice_aux_t;

  typedef struct packed {
    logic [fp_fmt_pkg::SLICE_WIDTH-1:0] value;
    fp_status_t                         status;
  } lane_res_t;

  typedef lane_res_t [fp_fmt_pkg::NUM_LANES-1:0] lane_res_array_t;

  localparam int unsigned PIPE_REGS = 2;

endpackage

// ==== hdl/fp_noncomp_slice.sv ====
// Non-computational FP slice for FP32 and packed FP16/FP8 lanes
// Sign injection and min/max with a valid/ready pipeline

`timescale 1ns/100ps

module fp_noncomp_slice (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [fp_fmt_pkg::SLICE_WIDTH-1:0]   operand_a_i,
  input  logic [fp_fmt_pkg::SLICE_WIDTH-1:0]   operand_b_i,
  input  fp_fmt_pkg::fp_fmt_e                  fmt_i,
  input  fp_op_pkg::fp_op_e                    op_i,
  input  logic                                 vectorial_i,
  input  logic [fp_op_pkg::TAG_WIDTH-1:0]      tag_i,
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  logic                                 flush_i,
  output logic [fp_fmt_pkg::SLICE_WIDTH-1:0]   result_o,
  output fp_op_pkg::fp_status_t                status_o,
  output logic [fp_op_pkg::TAG_WIDTH-1:0]      tag_o,
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output logic                                 busy_o
);

  logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::SLICE_WIDTH-1:0] lane_a;
  logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::SLICE_WIDTH-1:0] lane_b;
  logic [fp_fmt_pkg::NUM_LANES-1:0][1:0]                         lane_unboxed;

  fp_op_pkg::lane_res_array_t lane_res;
  fp_op_pkg::lane_res_array_t lane_res_q;
  fp_op_pkg::slice_aux_t      aux_in;
  fp_op_pkg::slice_aux_t      aux_q;

  assign aux_in = '{fmt: fmt_i, vectorial: vectorial_i, tag: tag_i};

  slice_decode u_decode (
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .fmt_i          (fmt_i),
    .vectorial_i    (vectorial_i),
    .lane_a_o       (lane_a),
    .lane_b_o       (lane_b),
    .lane_unboxed_o (lane_unboxed)
  );

  for (genvar i = 0; i < fp_fmt_pkg::NUM_LANES; i++) begin : gen_lanes
    noncomp_lane #(
      .LANE (i)
    ) u_lane (
      .a_i         (lane_a[i][fp_fmt_pkg::LANE_WIDTH[i]-1:0]),
      .b_i         (lane_b[i][fp_fmt_pkg::LANE_WIDTH[i]-1:0]),
      .a_unboxed_i (lane_unboxed[i][0]),
      .b_unboxed_i (lane_unboxed[i][1]),
      .fmt_i       (fmt_i),
      .op_i        (op_i),
      .res_o       (lane_res[i])
    );
  end

  // Data and sideband advance in lockstep, handshake taken from the control pipe
  pipe_stage #(
    .payload_t (fp_op_pkg::lane_res_array_t)
  ) u_data_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (),
    .data_i      (lane_res),
    .out_valid_o (),
    .out_ready_i (out_ready_i),
    .data_o      (lane_res_q),
    .busy_o      ()
  );

  pipe_stage #(
    .payload_t (fp_op_pkg::slice_aux_t)
  ) u_ctrl_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .data_i      (aux_in),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .data_o      (aux_q),
    .busy_o      (busy_o)
  );

  slice_result u_result (
    .lanes_i  (lane_res_q),
    .aux_i    (aux_q),
    .result_o (result_o),
    .status_o (status_o),
    .tag_o    (tag_o)
  );

endmodule

// ==== hdl/pipe_stage.sv ====
// Valid/ready pipeline of enable registers with flush
// Bubbles are popped, so a stage refills as soon as it is empty

`timescale 1ns/100ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t data_o,
  output logic     busy_o
);

  localparam int unsigned DEPTH = fp_op_pkg::PIPE_REGS;

  logic [DEPTH-1:0] valid_q;
  payload_t         data_q [DEPTH];
  logic [DEPTH:0]   ready;
  logic [DEPTH-1:0] src_valid;
  payload_t         src_data [DEPTH];

  // Register r loads when its item moves on or when it holds nothing
  always_comb begin : stage_ready
    ready[DEPTH] = out_ready_i;
    for (int r = DEPTH - 1; r >= 0; r--) begin
      ready[r] = ready[r+1] | ~valid_q[r];
    end
  end

  always_comb begin : stage_source
    src_valid[0] = in_valid_i;
    src_data[0]  = data_i;
    for (int r = 1; r < DEPTH; r++) begin
      src_valid[r] = valid_q[r-1];
      src_data[r]  = data_q[r-1];
    end
  end

  always_ff @(posedge clk_i) begin : valid_regs
    for (int r = 0; r < DEPTH; r++) begin
      if (rst_i || flush_i) begin
        valid_q[r] <= 1'b0;
      end else if (ready[r]) begin
        valid_q[r] <= src_valid[r];
      end
    end
  end

  // Payload only moves with a valid item
  always_ff @(posedge clk_i) begin : data_regs
    for (int r = 0; r < DEPTH; r++) begin
      if (ready[r] && src_valid[r]) begin
        data_q[r] <= src_data[r];
      end
    end
  end

  assign in_ready_o  = ready[0];
  assign out_valid_o = valid_q[DEPTH-1];
  assign data_o      = data_q[DEPTH-1];
  assign busy_o      = |valid_q;

endmodule

// ==== hdl/slice_decode.sv ====
// Operand slicing per SIMD lane and NaN-boxing check of scalar operands

`timescale 1ns/100ps

module slice_decode (
  input  logic [fp_fmt_pkg::SLICE_WIDTH-1:0]                        operand_a_i,
  input  logic [fp_fmt_pkg::SLICE_WIDTH-1:0]                        operand_b_i,
  input  fp_fmt_pkg::fp_fmt_e                                       fmt_i,
  input  logic                                                      vectorial_i,
  output logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::SLICE_WIDTH-1:0] lane_a_o,
  output logic [fp_fmt_pkg::NUM_LANES-1:0][fp_fmt_pkg::SLICE_WIDTH-1:0] lane_b_o,
  output logic [fp_fmt_pkg::NUM_LANES-1:0][1:0]                     lane_unboxed_o
);

  localparam int unsigned W = fp_fmt_pkg::SLICE_WIDTH;

  int unsigned fmt_width;
  logic [W-1:0] low_mask;
  logic         a_boxed;
  logic         b_boxed;

  assign fmt_width = fp_fmt_pkg::FP_WIDTH[fmt_i];

  // Ones over the format's own bits, zero above
  assign low_mask = ~({W{1'b1}} << fmt_width);

  // Boxed when every bit above the format width is one
  assign a_boxed = &(operand_a_i | low_mask);
  assign b_boxed = &(operand_b_i | low_mask);

  // ------------------------------
  // Lane operands
  // ------------------------------
  always_comb begin : lane_slicing
    for (int unsigned l = 0; l < fp_fmt_pkg::NUM_LANES; l++) begin
      lane_a_o[l] = operand_a_i >> (l * fmt_width);
      lane_b_o[l] = operand_b_i >> (l * fmt_width);
    end
  end

  // Only scalar operations go through the boxing check, and only lane 0 sees it
  always_comb begin : boxing_check
    lane_unboxed_o       = '0;
    lane_unboxed_o[0][0] = ~vectorial_i & ~a_boxed;
    lane_unboxed_o[0][1] = ~vectorial_i & ~b_boxed;
  end

endmodule

// ==== hdl/slice_result.sv ====
// Result assembly of the slice
// Packs lane results by format, NaN-boxes unused bits, merges status

`timescale 1ns/100ps

module slice_result (
  input  fp_op_pkg::lane_res_array_t           lanes_i,
  input  fp_op_pkg::slice_aux_t                aux_i,
  output logic [fp_fmt_pkg::SLICE_WIDTH-1:0]   result_o,
  output fp_op_pkg::fp_status_t                status_o,
  output logic [fp_op_pkg::TAG_WIDTH-1:0]      tag_o
);

  localparam int unsigned W = fp_fmt_pkg::SLICE_WIDTH;

  logic [fp_fmt_pkg::NUM_LANES-1:0] used;
  int unsigned                      fmt_width;
  logic [W-1:0]                     elem_mask;

  assign used      = fp_fmt_pkg::lanes_used(aux_i.fmt, aux_i.vectorial);
  assign fmt_width = fp_fmt_pkg::FP_WIDTH[aux_i.fmt];
  assign elem_mask = ~({W{1'b1}} << fmt_width);

  // ------------------------------
  // Packing and boxing
  // ------------------------------
  always_comb begin : pack
    logic [W-1:0] packed_res;
    packed_res = '1;
    for (int unsigned l = 0; l < fp_fmt_pkg::NUM_LANES; l++) begin
      if (used[l]) begin
        packed_res = (packed_res & ~(elem_mask << (l * fmt_width)))
                   | ((lanes_i[l].value & elem_mask) << (l * fmt_width));
      end
    end
    result_o = packed_res;
  end

  // Flags of idle lanes are ignored
  always_comb begin : collapse_status
    fp_op_pkg::fp_status_t acc;
    acc = '0;
    for (int unsigned l = 0; l < fp_fmt_pkg::NUM_LANES; l++) begin
      if (used[l]) begin
        acc = acc | lanes_i[l].status;
      end
    end
    status_o = acc;
  end

  assign tag_o = aux_i.tag;

endmodule

// ==== lane/noncomp_lane.sv ====
// One SIMD lane of the slice
// Sign injection and IEEE min/max for the formats this lane supports

`timescale 1ns/100ps

module noncomp_lane #(
  parameter int unsigned LANE = 0
) (
  input  logic [fp_fmt_pkg::LANE_WIDTH[LANE]-1:0] a_i,
  input  logic [fp_fmt_pkg::LANE_WIDTH[LANE]-1:0] b_i,
  input  logic                                    a_unboxed_i,
  input  logic                                    b_unboxed_i,
  input  fp_fmt_pkg::fp_fmt_e                     fmt_i,
  input  fp_op_pkg::fp_op_e                       op_i,
  output fp_op_pkg::lane_res_t                    res_o
);

  localparam int unsigned LW = fp_fmt_pkg::LANE_WIDTH[LANE];
  localparam logic [LW-1:0] ONES = '1;

  int unsigned   fw;
  int unsigned   eb;
  int unsigned   mb;
  logic          fmt_ok;
  logic [LW-1:0] val_mask, man_mask, exp_mask, quiet_bit, sign_bit, canon;
  logic [LW-1:0] a, b;
  logic          sign_a, sign_b, sign_res;
  logic          a_nan, b_nan, a_snan, b_snan, a_lt_b;
  logic [LW-1:0] res;
  logic          nv;

  assign fmt_ok = (fmt_i <= fp_fmt_pkg::FP8) && fp_fmt_pkg::lane_fmt_ok[LANE][fmt_i];
  assign fw     = fp_fmt_pkg::FP_WIDTH[fmt_i];
  assign eb     = fp_fmt_pkg::EXP_BITS[fmt_i];
  assign mb     = fp_fmt_pkg::MAN_BITS[fmt_i];

  // ------------------------------
  // Field masks of the active format
  // ------------------------------
  assign val_mask  = ~(ONES << fw);
  assign man_mask  = ~(ONES << mb);
  assign exp_mask  = (~(ONES << eb)) << mb;
  assign quiet_bit = man_mask & ~(man_mask >> 1);
  assign sign_bit  = LW'(1) << (fw - 1);
  assign canon     = fp_fmt_pkg::CANON_NAN[fmt_i][LW-1:0];

  // An operand that failed the boxing check reads as the canonical NaN
  assign a = a_unboxed_i ? canon : (a_i & val_mask);
  assign b = b_unboxed_i ? canon : (b_i & val_mask);

  assign sign_a = |(a & sign_bit);
  assign sign_b = |(b & sign_bit);
  assign a_nan  = ((a & exp_mask) == exp_mask) && ((a & man_mask) != '0);
  assign b_nan  = ((b & exp_mask) == exp_mask) && ((b & man_mask) != '0);
  assign a_snan = a_nan && ((a & quiet_bit) == '0);
  assign b_snan = b_nan && ((b & quiet_bit) == '0);

  // Sign-magnitude compare, -0 sorts below +0
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (!sign_a) begin
      a_lt_b = (a & ~sign_bit) < (b & ~sign_bit);
    end else begin
      a_lt_b = (a & ~sign_bit) > (b & ~sign_bit);
    end
  end

  always_comb begin : lane_op
    sign_res = sign_a;
    res      = '0;
    nv       = 1'b0;
    case (op_i)
      fp_op_pkg::SGNJ:  sign_res = sign_b;
      fp_op_pkg::SGNJN: sign_res = ~sign_b;
      fp_op_pkg::SGNJX: sign_res = sign_a ^ sign_b;
      default:          sign_res = sign_a;
    endcase
    case (op_i)
      fp_op_pkg::SGNJ, fp_op_pkg::SGNJN, fp_op_pkg::SGNJX: begin
        res = (a & ~sign_bit) | (sign_res ? sign_bit : '0);
      end
      fp_op_pkg::MIN, fp_op_pkg::MAX: begin
        nv = a_snan | b_snan;
        if (a_nan && b_nan) begin
          res = canon;
        end else if (a_nan) begin
          res = b;
        end else if (b_nan) begin
          res = a;
        end else begin
          res = ((op_i == fp_op_pkg::MIN) == a_lt_b) ? a : b;
        end
      end
      default: res = '0;
    endcase
  end

  // Unsupported format gives a zero result and clean flags
  assign res_o.value  = fmt_ok ? fp_fmt_pkg::SLICE_WIDTH'(res) : '0;
  assign res_o.status = '{nv: fmt_ok & nv, default: 1'b0};

endmodule

// ==== sim.f ====
+incdir+verification
common/fp_fmt_pkg.sv
common/fp_op_pkg.sv
hdl/pipe_stage.sv
hdl/slice_decode.sv
lane/noncomp_lane.sv
hdl/slice_result.sv
hdl/fp_noncomp_slice.sv
verification/tb_fp_noncomp_slice.sv

// ==== verification/slice_model.svh ====
// Reference model of the non-computational slice
// Element rules for sign injection and min/max, plus lane packing and boxing

`ifndef SLICE_MODEL_SVH
`define SLICE_MODEL_SVH

function automatic int unsigned fmt_width(fp_fmt_pkg::fp_fmt_e fmt);
  case (fmt)
    fp_fmt_pkg::FP16: return 16;
    fp_fmt_pkg::FP8:  return 8;
    default:          return 32;
  endcase
endfunction

function automatic int unsigned man_bits(fp_fmt_pkg::fp_fmt_e fmt);
  case (fmt)
    fp_fmt_pkg::FP16: return 10;
    fp_fmt_pkg::FP8:  return 2;
    default:          return 23;
  endcase
endfunction

// Exponent all ones with only the quiet bit set in the mantissa
function automatic logic [31:0] canonical_nan(fp_fmt_pkg::fp_fmt_e fmt);
  int unsigned fw;
  int unsigned mb;
  fw = fmt_width(fmt);
  mb = man_bits(fmt);
  return ((32'd1 << (fw - 1)) - (32'd1 << mb)) | (32'd1 << (mb - 1));
endfunction

function automatic logic [31:0] apply_element_op(fp_op_pkg::fp_op_e op, fp_fmt_pkg::fp_fmt_e fmt,
                                                 logic [31:0] a, logic [31:0] b,
                                                 output logic nv);
  int unsigned fw;
  int unsigned mb;
  logic [31:0] sgn;
  logic [31:0] mag;
  logic [31:0] man;
  logic        a_nan;
  logic        b_nan;
  longint      key_a;
  longint      key_b;
  fw    = fmt_width(fmt);
  mb    = man_bits(fmt);
  sgn   = 32'd1 << (fw - 1);
  mag   = sgn - 1;
  man   = (32'd1 << mb) - 1;
  // NaN magnitudes lie above the infinity pattern
  a_nan = (a & mag) > (mag & ~man);
  b_nan = (b & mag) > (mag & ~man);
  nv    = 1'b0;
  case (op)
    fp_op_pkg::SGNJ:  return (a & mag) | (b & sgn);
    fp_op_pkg::SGNJN: return (a & mag) | (~b & sgn);
    fp_op_pkg::SGNJX: return (a & mag) | ((a ^ b) & sgn);
    default: ;
  endcase
  nv = (a_nan && !a[mb-1]) || (b_nan && !b[mb-1]);
  if (a_nan && b_nan) return canonical_nan(fmt);
  if (a_nan) return b;
  if (b_nan) return a;
  // Ordered keys put every negative value, -0 included, below +0
  key_a = ((a & sgn) != 0) ? longint'(mag) - longint'(a & mag)
                           : longint'(mag) + 1 + longint'(a & mag);
  key_b = ((b & sgn) != 0) ? longint'(mag) - longint'(b & mag)
                           : longint'(mag) + 1 + longint'(b & mag);
  if (op == fp_op_pkg::MIN) return (key_a <= key_b) ? a : b;
  return (key_a >= key_b) ? a : b;
endfunction

function automatic logic [31:0] expected_slice(logic [31:0] a, logic [31:0] b,
                                               fp_fmt_pkg::fp_fmt_e fmt, fp_op_pkg::fp_op_e op,
                                               logic vectorial,
                                               output fp_op_pkg::fp_status_t status);
  int unsigned fw;
  int unsigned n;
  logic [31:0] emask;
  logic [31:0] ea;
  logic [31:0] eb;
  logic [31:0] elem;
  logic [31:0] res;
  logic        nv;
  fw     = fmt_width(fmt);
  emask  = (fw == 32) ? 32'hffff_ffff : ((32'd1 << fw) - 1);
  n      = vectorial ? 32 / fw : 1;
  res    = 32'hffff_ffff;
  status = '0;
  for (int unsigned l = 0; l < n; l++) begin
    ea = (a >> (l * fw)) & emask;
    eb = (b >> (l * fw)) & emask;
    // A narrow scalar needs ones above its own bits
    if (!vectorial && ((a | emask) != 32'hffff_ffff)) ea = canonical_nan(fmt);
    if (!vectorial && ((b | emask) != 32'hffff_ffff)) eb = canonical_nan(fmt);
    elem      = apply_element_op(op, fmt, ea, eb, nv);
    res       = (res & ~(emask << (l * fw))) | (elem << (l * fw));
    status.nv = status.nv | nv;
  end
  return res;
endfunction

`endif

// ==== verification/tb_fp_noncomp_slice.sv ====
// Testbench of the non-computational FP slice
// Random stimulus checked against a reference model, with back-pressure and flush

`timescale 1ns/100ps

module tb_fp_noncomp_slice;

  localparam int unsigned W       = fp_fmt_pkg::SLICE_WIDTH;
  localparam int unsigned TW      = fp_op_pkg::TAG_WIDTH;
  localparam int unsigned LATENCY = 2;
  localparam int unsigned TIMEOUT = 200;

  typedef struct {
    logic [W-1:0]          result;
    fp_op_pkg::fp_status_t status;
    logic [TW-1:0]         tag;
    int unsigned           cycle;
  } expect_t;

  logic                  clk_i;
  logic                  rst_i;
  logic [W-1:0]          operand_a_i;
  logic [W-1:0]          operand_b_i;
  fp_fmt_pkg::fp_fmt_e   fmt_i;
  fp_op_pkg::fp_op_e     op_i;
  logic                  vectorial_i;
  logic [TW-1:0]         tag_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic                  flush_i;
  logic [W-1:0]          result_o;
  fp_op_pkg::fp_status_t status_o;
  logic [TW-1:0]         tag_o;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  busy_o;

  expect_t       exp_q[$];
  int unsigned   cycle_cnt;
  int unsigned   errors;
  int unsigned   checks;
  int unsigned   items_out;
  int unsigned   test_err_base;
  int unsigned   ready_mode;
  logic          latency_check;
  logic          timed_out;
  logic [TW-1:0] next_tag;

  `include "slice_model.svh"

  fp_noncomp_slice fp_noncomp_slice_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .fmt_i       (fmt_i),
    .op_i        (op_i),
    .vectorial_i (vectorial_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Counts on the falling edge so it is stable at every rising edge
  initial begin : cycle_counter
    cycle_cnt = 0;
    forever begin
      @(negedge clk_i);
      cycle_cnt++;
    end
  end

  // Mode 0 holds ready high, 1 holds it low, 2 randomizes it
  initial begin : ready_driver
    out_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #10;
      case (ready_mode)
        0:       out_ready_i = 1'b1;
        1:       out_ready_i = 1'b0;
        default: out_ready_i = ($urandom % 3) != 0;
      endcase
    end
  end

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_result(input logic [W-1:0] expected, input logic [W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: result %h, expected %h", $time, actual, expected);
    end
  endtask

  task automatic check_status(input fp_op_pkg::fp_status_t expected,
                              input fp_op_pkg::fp_status_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: status %b, expected %b", $time, actual, expected);
    end
  endtask

  task automatic check_tag(input logic [TW-1:0] expected, input logic [TW-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: tag %0d, expected %0d (order broken)", $time, actual, expected);
    end
  endtask

  always @(posedge clk_i) begin : output_monitor
    expect_t e;
    if (!rst_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output transfer at %0t with no item pending in the model", $time);
      end else begin
        e = exp_q.pop_front();
        check_result(e.result, result_o);
        check_status(e.status, status_o);
        check_tag(e.tag, tag_o);
        if (latency_check && (cycle_cnt - e.cycle != LATENCY)) begin
          errors++;
          $display("Error at %0t: tag %0d left after %0d cycles, expected %0d",
                   $time, e.tag, cycle_cnt - e.cycle, LATENCY);
        end
        items_out++;
      end
    end
  end

  // ------------------------------
  // Run control
  // ------------------------------
  task automatic end_run();
    $display("Checks %0d, items out %0d, errors %0d", checks, items_out, errors);
    if (errors == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic abort_run(input string reason);
    timed_out = 1'b1;
    $display("Timeout at %0t: %s", $time, reason);
    end_run();
  endtask

  task automatic finish_test(input string name);
    $display("Test %s done with %0d errors", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #10;
    end
  endtask

  // Called 10 ns after a rising edge, returns 10 ns after the accepting edge
  task automatic send_item(input logic [W-1:0] a, input logic [W-1:0] b,
                           input fp_fmt_pkg::fp_fmt_e fmt, input fp_op_pkg::fp_op_e op,
                           input logic vec);
    expect_t               e;
    fp_op_pkg::fp_status_t st;
    int unsigned           n;
    logic                  accepted;
    operand_a_i = a;
    operand_b_i = b;
    fmt_i       = fmt;
    op_i        = op;
    vectorial_i = vec;
    tag_i       = next_tag;
    in_valid_i  = 1'b1;
    accepted    = 1'b0;
    n           = 0;
    while (!accepted) begin
      @(posedge clk_i);
      accepted = in_ready_o;
      n++;
      if (!accepted && n >= TIMEOUT) abort_run("input handshake never completed");
    end
    e.result = expected_slice(a, b, fmt, op, vec, st);
    e.status = st;
    e.tag    = next_tag;
    e.cycle  = cycle_cnt;
    exp_q.push_back(e);
    next_tag++;
    #10;
    in_valid_i = 1'b0;
  endtask

  task automatic drain();
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #10;
      n++;
      if (n >= TIMEOUT) abort_run("expected items never left the slice");
    end
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  function automatic logic [W-1:0] special_elem(fp_fmt_pkg::fp_fmt_e fmt);
    int unsigned  fw;
    logic [W-1:0] sgn;
    logic [W-1:0] inf;
    fw  = fmt_width(fmt);
    sgn = 32'd1 << (fw - 1);
    inf = sgn - (32'd1 << man_bits(fmt));
    case ($urandom % 7)
      0:       return '0;
      1:       return sgn;
      2:       return canonical_nan(fmt) | ($urandom & sgn);
      3:       return inf | 32'd1 | ($urandom & sgn);
      4:       return inf | ($urandom & sgn);
      default: return $urandom & ((fw == 32) ? 32'hffff_ffff : ((32'd1 << fw) - 1));
    endcase
  endfunction

  function automatic logic [W-1:0] box(logic [W-1:0] elem, fp_fmt_pkg::fp_fmt_e fmt);
    int unsigned fw;
    fw = fmt_width(fmt);
    return (fw == 32) ? elem : (elem | ~((32'd1 << fw) - 1));
  endfunction

  // Upper bits with at least one zero at a random position
  function automatic logic [W-1:0] unboxed(fp_fmt_pkg::fp_fmt_e fmt);
    int unsigned  fw;
    logic [W-1:0] v;
    fw = fmt_width(fmt);
    v  = $urandom;
    v[fw + ($urandom % (W - fw))] = 1'b0;
    return v;
  endfunction

  function automatic logic [W-1:0] vector_operand(fp_fmt_pkg::fp_fmt_e fmt);
    int unsigned  fw;
    logic [W-1:0] v;
    fw = fmt_width(fmt);
    v  = '0;
    for (int unsigned l = 0; l < W / fw; l++) begin
      v = v | (special_elem(fmt) << (l * fw));
    end
    return v;
  endfunction

  task automatic send_random();
    fp_fmt_pkg::fp_fmt_e fmt;
    logic                vec;
    fmt = fp_fmt_pkg::fp_fmt_e'($urandom % 3);
    vec = $urandom % 2;
    if (vec) begin
      send_item(vector_operand(fmt), vector_operand(fmt), fmt,
                fp_op_pkg::fp_op_e'($urandom % 5), 1'b1);
    end else begin
      send_item(box(special_elem(fmt), fmt), box(special_elem(fmt), fmt), fmt,
                fp_op_pkg::fp_op_e'($urandom % 5), 1'b0);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : stimulus
    fp_fmt_pkg::fp_fmt_e fmt;
    int unsigned         seed;
    seed          = $urandom(30054);
    rst_i         = 1'b1;
    operand_a_i   = '0;
    operand_b_i   = '0;
    fmt_i         = fp_fmt_pkg::FP32;
    op_i          = fp_op_pkg::SGNJ;
    vectorial_i   = 1'b0;
    tag_i         = '0;
    in_valid_i    = 1'b0;
    flush_i       = 1'b0;
    errors        = 0;
    checks        = 0;
    items_out     = 0;
    test_err_base = 0;
    ready_mode    = 0;
    latency_check = 1'b0;
    timed_out     = 1'b0;
    next_tag      = '0;
    repeat (10) @(posedge clk_i);
    #10;
    rst_i = 1'b0;

    if (out_valid_o !== 1'b0 || busy_o !== 1'b0 || in_ready_o !== 1'b1) begin
      errors++;
      $display("Error at %0t: handshake outputs not idle after reset", $time);
    end
    for (int i = 0; i < 60; i++) begin
      fmt = fp_fmt_pkg::fp_fmt_e'($urandom % 3);
      send_item(box(special_elem(fmt), fmt), box(special_elem(fmt), fmt), fmt,
                fp_op_pkg::fp_op_e'($urandom % 3), 1'b0);
    end
    drain();
    finish_test("sign_injection");

    for (int i = 0; i < 60; i++) begin
      fmt = ($urandom % 2) ? fp_fmt_pkg::FP16 : fp_fmt_pkg::FP8;
      send_item(vector_operand(fmt), vector_operand(fmt), fmt,
                ($urandom % 2) ? fp_op_pkg::MIN : fp_op_pkg::MAX, 1'b1);
    end
    drain();
    finish_test("vector_min_max");

    for (int i = 0; i < 40; i++) begin
      fmt = ($urandom % 2) ? fp_fmt_pkg::FP16 : fp_fmt_pkg::FP8;
      send_item(unboxed(fmt), ($urandom % 2) ? unboxed(fmt) : box(special_elem(fmt), fmt),
                fmt, fp_op_pkg::fp_op_e'($urandom % 5), 1'b0);
    end
    for (int i = 0; i < 20; i++) begin
      send_item(special_elem(fp_fmt_pkg::FP32), special_elem(fp_fmt_pkg::FP32),
                fp_fmt_pkg::FP32, fp_op_pkg::fp_op_e'($urandom % 5), 1'b1);
    end
    drain();
    finish_test("nan_boxing");

    ready_mode = 2;
    for (int i = 0; i < 60; i++) begin
      send_random();
      idle($urandom % 3);
    end
    drain();
    ready_mode = 0;
    idle(2);
    latency_check = 1'b1;
    for (int i = 0; i < 20; i++) begin
      send_random();
    end
    drain();
    latency_check = 1'b0;
    finish_test("back_pressure");

    // Two items parked in the pipeline, then dropped
    ready_mode = 1;
    idle(2);
    send_random();
    send_random();
    flush_i = 1'b1;
    @(posedge clk_i);
    #10;
    flush_i = 1'b0;
    exp_q.delete();
    if (busy_o !== 1'b0 || out_valid_o !== 1'b0) begin
      errors++;
      $display("Error at %0t: slice still busy after flush", $time);
    end
    ready_mode = 0;
    idle(2);
    for (int i = 0; i < 20; i++) begin
      send_random();
    end
    drain();
    finish_test("flush");

    end_run();
  end

endmodule
